// File: all.f
+incdir+hdl
hdl/oflow_core_pkg.sv
hdl/oflow_ctrl_pkg.sv
hdl/oflow_pe.sv
hdl/oflow_core_fsm_top.sv
hdl/oflow_core_fsm_fe.sv
hdl/oflow_core_fsm_registration.sv
hdl/oflow_core_top.sv
tb/oflow_core_tb.sv

// File: hdl/oflow_core_fsm_fe.sv
// oflow set dispatcher
`timescale 1ns/100ps
`include "oflow_params.svh"

module oflow_core_fsm_fe (
	input  logic                       clk,
	input  logic                       reset_N,
	// frame sequencer
	input  oflow_core_pkg::set_cnt_t   num_of_sets,
	input  logic                       start_pe,
	// remaining boxes, counting the current set
	input  oflow_core_pkg::bbox_cnt_t  counter_of_remain_bboxes,
	input  logic                       new_set,
	input  oflow_core_pkg::frame_num_t frame_num,
	output oflow_core_pkg::set_cnt_t   counter_set_fe,
	// registration / score calculation
	input  logic                       done_registration,
	input  logic                       done_score_calc,
	output logic                       done_fe,
	// PE array
	input  oflow_core_pkg::pe_mask_t   done_fe_i,
	output oflow_core_pkg::pe_mask_t   start_fe_i,
	output oflow_core_pkg::pe_mask_t   not_start_fe_i,
	output logic                       ready_new_set
);

	oflow_ctrl_pkg::fe_state_t current_state;
	oflow_ctrl_pkg::fe_state_t next_state;

	// second cycle of fe state
	logic                     in_fe_q;
	// mask sent with the last start
	oflow_core_pkg::pe_mask_t active_mask_q;
	// previous set post-processed
	logic                     post_done_q;
	logic                     post_strobe;
	logic                     post_ok;
	logic                     last_set;
	logic                     leave_wait;
	oflow_core_pkg::pe_mask_t set_mask;

	// ------------------------------------------------------------------------
	// set mask
	// ------------------------------------------------------------------------
	assign last_set = (counter_set_fe == oflow_core_pkg::set_cnt_t'(num_of_sets - 1'b1));

	// low r bits on the last set
	assign set_mask = last_set ?
		oflow_core_pkg::pe_mask_t'({`PE_NUM{1'b1}} >> (`PE_NUM - counter_of_remain_bboxes)) :
		{`PE_NUM{1'b1}};

	// strobe follows the frame: registration on frame 0 only
	assign post_strobe = (frame_num == '0) ? done_registration : done_score_calc;

	// set 0 never waits
	assign post_ok = (counter_set_fe == '0) || post_done_q || post_strobe;

	// ------------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------------
	always_comb begin
		next_state     = current_state;
		start_fe_i     = '0;
		not_start_fe_i = '0;
		done_fe        = 1'b0;
		leave_wait     = 1'b0;
		case (current_state)
			oflow_ctrl_pkg::fe_idle_st: begin
				if (start_pe) begin
					next_state = oflow_ctrl_pkg::fe_run_st;
				end
			end
			oflow_ctrl_pkg::fe_run_st: begin
				// first cycle lets base and remaining settle
				if (in_fe_q) begin
					if (counter_set_fe < num_of_sets) begin
						start_fe_i     = set_mask;
						not_start_fe_i = ~set_mask;
						next_state     = oflow_ctrl_pkg::fe_wait_st;
					end else begin
						next_state = oflow_ctrl_pkg::fe_idle_st;
					end
				end
			end
			oflow_ctrl_pkg::fe_wait_st: begin
				// all started PEs done, previous set out of post-processing
				done_fe = (done_fe_i == active_mask_q) && post_ok;
				if (done_fe) begin
					leave_wait = new_set;
					next_state = new_set ? oflow_ctrl_pkg::fe_run_st : oflow_ctrl_pkg::fe_idle_st;
				end
			end
			default: next_state = oflow_ctrl_pkg::fe_idle_st;
		endcase
	end

	// ------------------------------------------------------------------------
	// registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			current_state  <= oflow_ctrl_pkg::fe_idle_st;
			in_fe_q        <= 1'b0;
			active_mask_q  <= '0;
			counter_set_fe <= '0;
			ready_new_set  <= 1'b0;
			post_done_q    <= 1'b0;
		end else begin
			current_state <= next_state;
			in_fe_q       <= (current_state == oflow_ctrl_pkg::fe_run_st);
			ready_new_set <= leave_wait;
			if (start_fe_i != '0) begin
				active_mask_q <= start_fe_i;
			end
			// set counter
			if (current_state == oflow_ctrl_pkg::fe_idle_st) begin
				counter_set_fe <= '0;
			end else if (leave_wait) begin
				counter_set_fe <= counter_set_fe + 1'b1;
			end
			// sticky strobe, the pulse may come before the PEs finish
			if (current_state == oflow_ctrl_pkg::fe_idle_st || done_fe) begin
				post_done_q <= 1'b0;
			end else if (post_strobe) begin
				post_done_q <= 1'b1;
			end
		end
	end

	// one started PE per remaining box up to PE_NUM
	a_start_mask: assert property (@(posedge clk) disable iff (!reset_N)
		(start_fe_i != '0) |->
		($countones(start_fe_i) == ((counter_of_remain_bboxes > `PE_NUM) ?
			`PE_NUM : counter_of_remain_bboxes)));

endmodule

// File: hdl/oflow_core_fsm_registration.sv
// oflow set post-processing
`timescale 1ns/100ps
`include "oflow_params.svh"

module oflow_core_fsm_registration (
	input  logic                                    clk,
	input  logic                                    reset_N,
	// dispatcher
	input  logic                                    done_fe,
	input  oflow_core_pkg::frame_num_t              frame_num,
	input  oflow_core_pkg::set_cnt_t                counter_set_fe,
	// PE array
	input  oflow_core_pkg::pe_mask_t                active_mask_i,
	input  oflow_core_pkg::feature_t [`PE_NUM-1:0]  pe_feature_i,
	input  logic                                    last_set_i,
	// strobes back to dispatcher
	output logic                                    done_registration,
	output logic                                    done_score_calc,
	// set result
	output logic                                    set_valid_o,
	output oflow_core_pkg::set_cnt_t                set_index_o,
	output oflow_core_pkg::pe_mask_t                set_mask_o,
	output oflow_core_pkg::feature_t                set_feature_o,
	output logic                                    frame_done_o
);

	oflow_ctrl_pkg::reg_state_t state_q;
	logic                       done_fe_q;
	logic                       fe_rise;
	logic [`LAT_CNT_LEN-1:0]    lat_cnt;
	oflow_core_pkg::feature_t   fold;
	// captured with the set
	logic                       score_q;
	logic                       last_q;

	assign fe_rise = done_fe && !done_fe_q;

	// xor of the active features
	always_comb begin
		fold = '0;
		for (int i = 0; i < `PE_NUM; i++) begin
			if (active_mask_i[i]) begin
				fold ^= pe_feature_i[i];
			end
		end
	end

	// set payload
	always_ff @(posedge clk) begin
		if (fe_rise) begin
			set_feature_o <= fold;
			set_mask_o    <= active_mask_i;
			set_index_o   <= counter_set_fe;
			score_q       <= (frame_num != '0);
			last_q        <= last_set_i;
		end
	end

	// ------------------------------------------------------------------------
	// latency FSM, rise to set_valid_o is LAT cycles
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state_q      <= oflow_ctrl_pkg::reg_idle_st;
			done_fe_q    <= 1'b0;
			lat_cnt      <= '0;
			frame_done_o <= 1'b0;
		end else begin
			done_fe_q    <= done_fe;
			frame_done_o <= set_valid_o && last_q;
			if (fe_rise) begin
				state_q <= oflow_ctrl_pkg::reg_busy_st;
				lat_cnt <= (frame_num == '0) ? `LAT_CNT_LEN'(`REG_LAT - 2) :
					`LAT_CNT_LEN'(`SCORE_LAT - 2);
			end else if (state_q == oflow_ctrl_pkg::reg_busy_st) begin
				if (lat_cnt == '0) begin
					state_q <= oflow_ctrl_pkg::reg_done_st;
				end else begin
					lat_cnt <= lat_cnt - 1'b1;
				end
			end else if (state_q == oflow_ctrl_pkg::reg_done_st) begin
				state_q <= oflow_ctrl_pkg::reg_idle_st;
			end
		end
	end

	assign set_valid_o       = (state_q == oflow_ctrl_pkg::reg_done_st);
	assign done_registration = set_valid_o && !score_q;
	assign done_score_calc   = set_valid_o && score_q;

	// only the strobe that fits the current frame number
	a_one_strobe: assert property (@(posedge clk) disable iff (!reset_N)
		(done_registration || done_score_calc) |->
		(done_registration == (frame_num == '0)) && (done_score_calc == (frame_num != '0)));

	// dispatcher holds the next set until this one is out
	a_no_overlap: assert property (@(posedge clk) disable iff (!reset_N)
		fe_rise |-> (state_q != oflow_ctrl_pkg::reg_busy_st));

endmodule

// File: hdl/oflow_core_fsm_top.sv
// oflow frame sequencer
`timescale 1ns/100ps
`include "oflow_params.svh"

module oflow_core_fsm_top (
	input  logic                       clk,
	input  logic                       reset_N,
	// frame request
	input  logic                       frame_start_i,
	input  oflow_core_pkg::bbox_cnt_t  bbox_count_i,
	// from dispatcher
	input  oflow_core_pkg::set_cnt_t   counter_set_fe,
	input  logic                       ready_new_set,
	// from registration
	input  logic                       frame_done_i,
	// to dispatcher
	output oflow_core_pkg::set_cnt_t   num_of_sets,
	output logic                       start_pe,
	output oflow_core_pkg::bbox_cnt_t  counter_of_remain_bboxes,
	output logic                       new_set,
	output oflow_core_pkg::frame_num_t frame_num,
	// to PE array
	output oflow_core_pkg::bbox_cnt_t  bbox_base_o,
	output logic                       busy_o
);

	oflow_ctrl_pkg::top_state_t state_q;

	// ------------------------------------------------------------------------
	// frame state, set bookkeeping
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state_q                  <= oflow_ctrl_pkg::top_idle_st;
			start_pe                 <= 1'b0;
			num_of_sets              <= '0;
			counter_of_remain_bboxes <= '0;
			bbox_base_o              <= '0;
			frame_num                <= '0;
		end else begin
			// single cycle kick
			start_pe <= 1'b0;
			case (state_q)
				oflow_ctrl_pkg::top_idle_st: begin
					if (frame_start_i) begin
						state_q <= oflow_ctrl_pkg::top_run_st;
						// ceil(n / PE_NUM)
						num_of_sets <= oflow_core_pkg::set_cnt_t'(
							(bbox_count_i + (`PE_NUM - 1)) / `PE_NUM);
						counter_of_remain_bboxes <= bbox_count_i;
						bbox_base_o              <= '0;
						start_pe                 <= 1'b1;
					end
				end
				oflow_ctrl_pkg::top_run_st: begin
					// next set, step base and remaining together
					if (ready_new_set) begin
						bbox_base_o              <= bbox_base_o + `PE_NUM;
						counter_of_remain_bboxes <= counter_of_remain_bboxes - `PE_NUM;
					end
					// last set post-processed
					if (frame_done_i) begin
						state_q   <= oflow_ctrl_pkg::top_idle_st;
						frame_num <= frame_num + 1'b1;
					end
				end
				default: state_q <= oflow_ctrl_pkg::top_idle_st;
			endcase
		end
	end

	assign busy_o = (state_q == oflow_ctrl_pkg::top_run_st);

	// another set still to dispatch after the current one
	assign new_set = busy_o &&
		(oflow_core_pkg::set_cnt_t'(counter_set_fe + 1'b1) < num_of_sets);

	// no new frame while one is in flight
	a_no_start_busy: assert property (@(posedge clk) disable iff (!reset_N)
		frame_start_i |-> !busy_o);

endmodule

// File: hdl/oflow_core_pkg.sv
// oflow core data types
`include "oflow_params.svh"

package oflow_core_pkg;

	// box count or box index
	typedef logic [`REMAIN_BBOX_LEN-1:0] bbox_cnt_t;

	// set count or set index
	typedef logic [`SET_LEN-1:0] set_cnt_t;

	// frame number
	typedef logic [`TOTAL_FRAME_NUM_WIDTH-1:0] frame_num_t;

	// one bit per PE
	typedef logic [`PE_NUM-1:0] pe_mask_t;

	// feature of a box or of a whole set
	typedef logic [`FEATURE_LEN-1:0] feature_t;

endpackage

// File: hdl/oflow_core_top.sv
// oflow core feature-extraction top
`timescale 1ns/100ps
`include "oflow_params.svh"

module oflow_core_top (
	input  logic                       clk,
	input  logic                       reset_N,
	input  logic                       frame_start_i,
	input  oflow_core_pkg::bbox_cnt_t  bbox_count_i,
	output logic                       busy_o,
	output logic                       set_valid_o,
	output oflow_core_pkg::set_cnt_t   set_index_o,
	output oflow_core_pkg::pe_mask_t   set_mask_o,
	output oflow_core_pkg::feature_t   set_feature_o,
	output logic                       frame_done_o,
	output oflow_core_pkg::frame_num_t frame_num_o
);

	// sequencer to dispatcher
	oflow_core_pkg::set_cnt_t                num_of_sets;
	oflow_core_pkg::set_cnt_t                counter_set_fe;
	oflow_core_pkg::bbox_cnt_t               counter_of_remain_bboxes;
	oflow_core_pkg::bbox_cnt_t               bbox_base;
	logic                                    start_pe;
	logic                                    new_set;
	logic                                    ready_new_set;
	// dispatcher and post-processing
	logic                                    done_fe;
	logic                                    done_registration;
	logic                                    done_score_calc;
	// PE array
	oflow_core_pkg::pe_mask_t                start_fe_i;
	oflow_core_pkg::pe_mask_t                not_start_fe_i;
	oflow_core_pkg::pe_mask_t                done_fe_i;
	oflow_core_pkg::feature_t [`PE_NUM-1:0]  pe_feature;

	oflow_core_fsm_top u_fsm_top (
		.clk (clk), .reset_N (reset_N), .frame_start_i (frame_start_i),
		.bbox_count_i (bbox_count_i), .counter_set_fe (counter_set_fe),
		.ready_new_set (ready_new_set), .frame_done_i (frame_done_o),
		.num_of_sets (num_of_sets), .start_pe (start_pe),
		.counter_of_remain_bboxes (counter_of_remain_bboxes), .new_set (new_set),
		.frame_num (frame_num_o), .bbox_base_o (bbox_base), .busy_o (busy_o)
	);

	oflow_core_fsm_fe u_fsm_fe (
		.clk (clk), .reset_N (reset_N), .num_of_sets (num_of_sets), .start_pe (start_pe),
		.counter_of_remain_bboxes (counter_of_remain_bboxes), .new_set (new_set),
		.frame_num (frame_num_o), .counter_set_fe (counter_set_fe),
		.done_registration (done_registration), .done_score_calc (done_score_calc),
		.done_fe (done_fe), .done_fe_i (done_fe_i), .start_fe_i (start_fe_i),
		.not_start_fe_i (not_start_fe_i), .ready_new_set (ready_new_set)
	);

	// done mask equals the start mask at the rising edge of done_fe
	oflow_core_fsm_registration u_fsm_reg (
		.clk (clk), .reset_N (reset_N), .done_fe (done_fe), .frame_num (frame_num_o),
		.counter_set_fe (counter_set_fe), .active_mask_i (done_fe_i),
		.pe_feature_i (pe_feature), .last_set_i (!new_set),
		.done_registration (done_registration), .done_score_calc (done_score_calc),
		.set_valid_o (set_valid_o), .set_index_o (set_index_o), .set_mask_o (set_mask_o),
		.set_feature_o (set_feature_o), .frame_done_o (frame_done_o)
	);

	// PE g takes box base + g
	for (genvar g = 0; g < `PE_NUM; g++) begin : g_pe
		oflow_pe u_pe (
			.clk (clk), .reset_N (reset_N),
			.start_i (start_fe_i[g]), .clear_i (not_start_fe_i[g]),
			.bbox_index_i (oflow_core_pkg::bbox_cnt_t'(bbox_base + g)),
			.frame_num_i (frame_num_o), .done_o (done_fe_i[g]), .feature_o (pe_feature[g])
		);
	end

endmodule

// File: hdl/oflow_ctrl_pkg.sv
// oflow control state types
package oflow_ctrl_pkg;

	// set dispatcher
	typedef enum logic [1:0] {fe_idle_st, fe_run_st, fe_wait_st} fe_state_t;

	// registration / score calculation
	typedef enum logic [1:0] {reg_idle_st, reg_busy_st, reg_done_st} reg_state_t;

	// frame sequencer
	typedef enum logic {top_idle_st, top_run_st} top_state_t;

endpackage

// File: hdl/oflow_params.svh
// oflow core parameters
`ifndef OFLOW_PARAMS_SVH
`define OFLOW_PARAMS_SVH

// ----------------------------------------------------------------------------
// PE array
// ----------------------------------------------------------------------------
// number of PEs, also the largest set
`define PE_NUM 8

// ----------------------------------------------------------------------------
// field widths
// ----------------------------------------------------------------------------
// set count and set counter
`define SET_LEN 4
// box counts, up to 127 boxes
`define REMAIN_BBOX_LEN 7
// frame counter
`define TOTAL_FRAME_NUM_WIDTH 8
// feature value
`define FEATURE_LEN 16

// post-processing latencies in cycles, both at least 2
`define REG_LAT 3
`define SCORE_LAT 5
// latency counter
`define LAT_CNT_LEN 4

`endif

// File: hdl/oflow_pe.sv
// oflow feature-extraction PE
`timescale 1ns/100ps

module oflow_pe (
	input  logic                       clk,
	input  logic                       reset_N,
	// dispatcher strobes
	input  logic                       start_i,
	input  logic                       clear_i,
	// work item
	input  oflow_core_pkg::bbox_cnt_t  bbox_index_i,
	input  oflow_core_pkg::frame_num_t frame_num_i,
	// held until next start or clear
	output logic                       done_o,
	output oflow_core_pkg::feature_t   feature_o
);

	oflow_core_pkg::bbox_cnt_t  bbox_q;
	oflow_core_pkg::frame_num_t frame_q;
	logic [2:0]                 cnt_q;
	logic                       busy_q;

	// work item kept for the feature
	always_ff @(posedge clk) begin
		if (start_i) begin
			bbox_q  <= bbox_index_i;
			frame_q <= frame_num_i;
		end
	end

	// done lands 2 + (index mod 4) cycles after start
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy_q    <= 1'b0;
			cnt_q     <= '0;
			done_o    <= 1'b0;
			feature_o <= '0;
		end else if (clear_i) begin
			busy_q    <= 1'b0;
			cnt_q     <= '0;
			done_o    <= 1'b0;
			feature_o <= '0;
		end else if (start_i) begin
			busy_q <= 1'b1;
			cnt_q  <= 3'd1 + 3'(bbox_index_i[1:0]);
			done_o <= 1'b0;
		end else if (busy_q) begin
			if (cnt_q == 3'd1) begin
				busy_q <= 1'b0;
				done_o <= 1'b1;
				// index * 0x9E37 + frame * 0x0101, mod 2^16
				feature_o <= oflow_core_pkg::feature_t'(bbox_q) * 16'h9E37 +
					oflow_core_pkg::feature_t'(frame_q) * 16'h0101;
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the oflow core testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module oflow_core_tb -o oflow_sim \
	&& ./obj_dir/oflow_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -q '^ALL CHECKS PASSED$' sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb/oflow_core_tb.sv
// oflow core testbench
`timescale 1ns/100ps
`include "oflow_params.svh"

module oflow_core_tb;

	// at most 5 sets per frame, 20 cycles per set is generous
	localparam int FRAMES     = 12;
	localparam int MAX_CYCLES = FRAMES * 6 * 20 + 200;

	logic                       clk;
	logic                       reset_N;
	logic                       frame_start_i;
	oflow_core_pkg::bbox_cnt_t  bbox_count_i;
	logic                       busy_o;
	logic                       set_valid_o;
	oflow_core_pkg::set_cnt_t   set_index_o;
	oflow_core_pkg::pe_mask_t   set_mask_o;
	oflow_core_pkg::feature_t   set_feature_o;
	logic                       frame_done_o;
	oflow_core_pkg::frame_num_t frame_num_o;

	// expected set results, oldest first
	oflow_core_pkg::feature_t   exp_feature_q[$];
	oflow_core_pkg::pe_mask_t   exp_mask_q[$];
	oflow_core_pkg::set_cnt_t   exp_index_q[$];

	oflow_core_pkg::frame_num_t cur_frame;
	int                         check_cnt;
	int                         err_cnt;
	int                         test_cnt;
	int                         frames_done;
	int                         cycle_cnt = 0;
	int                         errs_before;
	int                         n;
	int                         gap;
	// frame_done_o seen, follow-up checks next cycle
	logic                       after_done;
	logic                       prev_valid;

	oflow_core_top dut (
		.clk (clk), .reset_N (reset_N), .frame_start_i (frame_start_i),
		.bbox_count_i (bbox_count_i), .busy_o (busy_o), .set_valid_o (set_valid_o),
		.set_index_o (set_index_o), .set_mask_o (set_mask_o),
		.set_feature_o (set_feature_o), .frame_done_o (frame_done_o),
		.frame_num_o (frame_num_o)
	);

	// 100 ns period
	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	// index * 0x9E37 + frame * 0x0101, mod 2^16
	function automatic oflow_core_pkg::feature_t box_feature(int idx, int frame);
		int sum;
		sum = idx * 'h9E37 + frame * 'h0101;
		return oflow_core_pkg::feature_t'(sum & 'hFFFF);
	endfunction

	task automatic add_frame_model(int boxes, oflow_core_pkg::frame_num_t f);
		int                       nsets;
		int                       active;
		oflow_core_pkg::pe_mask_t mask;
		oflow_core_pkg::feature_t acc;
		nsets = (boxes + `PE_NUM - 1) / `PE_NUM;
		for (int s = 0; s < nsets; s++) begin
			// full set or the remainder
			active = boxes - s * `PE_NUM;
			if (active > `PE_NUM) begin
				active = `PE_NUM;
			end
			mask = '0;
			acc  = '0;
			for (int i = 0; i < active; i++) begin
				mask[i] = 1'b1;
				acc ^= box_feature(s * `PE_NUM + i, int'(f));
			end
			exp_feature_q.push_back(acc);
			exp_mask_q.push_back(mask);
			exp_index_q.push_back(oflow_core_pkg::set_cnt_t'(s));
		end
	endtask

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------
	task automatic check_feature(string name, oflow_core_pkg::feature_t exp,
		oflow_core_pkg::feature_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_mask(string name, oflow_core_pkg::pe_mask_t exp,
		oflow_core_pkg::pe_mask_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_set(string name, oflow_core_pkg::set_cnt_t exp,
		oflow_core_pkg::set_cnt_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_frame(string name, oflow_core_pkg::frame_num_t exp,
		oflow_core_pkg::frame_num_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_level(string name, logic exp, logic act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic report_test(string name, int errs_at_start);
		test_cnt++;
		if (err_cnt == errs_at_start) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: fail, %0d errors", name, err_cnt - errs_at_start);
		end
	endtask

	// ------------------------------------------------------------------------
	// output monitor, sampled mid-cycle
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (reset_N) begin
			// sequencer back to idle, frame counter stepped
			if (after_done) begin
				check_level("busy_o after frame_done_o", 1'b0, busy_o);
				check_frame("frame_num_o after frame_done_o",
					oflow_core_pkg::frame_num_t'(cur_frame + 1'b1), frame_num_o);
				after_done = 1'b0;
				frames_done++;
			end
			if (set_valid_o) begin
				if (exp_index_q.size() == 0) begin
					err_cnt++;
					$display("unexpected set_valid_o pulse in frame %0d", cur_frame);
				end else begin
					check_set($sformatf("frame %0d set_index_o", cur_frame),
						exp_index_q.pop_front(), set_index_o);
					check_mask($sformatf("frame %0d set_mask_o", cur_frame),
						exp_mask_q.pop_front(), set_mask_o);
					check_feature($sformatf("frame %0d set_feature_o", cur_frame),
						exp_feature_q.pop_front(), set_feature_o);
				end
			end
			if (frame_done_o) begin
				check_frame("frame_num_o with frame_done_o", cur_frame, frame_num_o);
				if (exp_index_q.size() != 0) begin
					err_cnt++;
					$display("frame %0d ended with %0d set_valid_o pulses missing",
						cur_frame, exp_index_q.size());
				end
				// done comes one cycle after the last set
				if (!prev_valid) begin
					err_cnt++;
					$display("frame_done_o of frame %0d did not follow a set_valid_o pulse",
						cur_frame);
				end
				after_done = 1'b1;
			end
			prev_valid = set_valid_o;
		end
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(39));
		reset_N       = 1'b0;
		frame_start_i = 1'b0;
		bbox_count_i  = '0;
		cur_frame     = '0;
		after_done    = 1'b0;
		prev_valid    = 1'b0;
		check_cnt     = 0;
		err_cnt       = 0;
		test_cnt      = 0;
		frames_done   = 0;
		repeat (3) @(posedge clk);
		#5 reset_N = 1'b1;

		// quiet outputs after reset
		errs_before = err_cnt;
		repeat (4) begin
			@(negedge clk);
			check_level("busy_o after reset", 1'b0, busy_o);
			check_level("set_valid_o after reset", 1'b0, set_valid_o);
			check_level("frame_done_o after reset", 1'b0, frame_done_o);
			check_frame("frame_num_o after reset", '0, frame_num_o);
		end
		report_test("reset", errs_before);

		for (int f = 0; f < FRAMES; f++) begin
			n = ($urandom % 40) + 1;
			// every fourth frame an exact multiple of PE_NUM
			if (f % 4 == 3) begin
				n = `PE_NUM * (($urandom % 5) + 1);
			end
			gap         = $urandom % 4;
			errs_before = err_cnt;
			cur_frame   = oflow_core_pkg::frame_num_t'(f);
			add_frame_model(n, cur_frame);
			repeat (gap + 1) @(posedge clk);
			#5;
			frame_start_i = 1'b1;
			bbox_count_i  = oflow_core_pkg::bbox_cnt_t'(n);
			@(posedge clk);
			#5;
			frame_start_i = 1'b0;
			wait (frames_done == f + 1);
			report_test($sformatf("frame_%0d with %0d boxes", f, n), errs_before);
		end

		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// run limit
	initial begin
		wait (cycle_cnt >= MAX_CYCLES);
		$display("timeout after %0d cycles, frame %0d never finished", cycle_cnt, cur_frame);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule
